// File: logic/hello_pkg.sv
// ---------------------------------------------------------------------
// Shared types and constants for the hello register block
// Bus structs for the AXI-Lite style slave port, register map,
// the write-strobe struct between controller and register bank
// Imported by every RTL module and by the testbench
// ---------------------------------------------------------------------
`default_nettype none

package hello_pkg;

  // Bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int RESP_W = 2;

  typedef logic [DATA_W-1:0] ocl_data_t;
  typedef logic [ADDR_W-1:0] ocl_addr_t;
  typedef logic [RESP_W-1:0] ocl_resp_t;

  // Everything the master drives
  typedef struct packed {
    logic              awvalid;
    ocl_addr_t         awaddr;
    logic              wvalid;
    ocl_data_t         wdata;
    // Carried only, every write is full word
    logic [STRB_W-1:0] wstrb;
    logic              bready;
    logic              arvalid;
    ocl_addr_t         araddr;
    logic              rready;
  } ocl_req_t;

  // Everything the slave drives
  typedef struct packed {
    logic      awready;
    logic      wready;
    logic      bvalid;
    ocl_resp_t bresp;
    logic      arready;
    logic      rvalid;
    ocl_data_t rdata;
    ocl_resp_t rresp;
  } ocl_rsp_t;

  // Controller to register bank, en is a one-cycle strobe
  typedef struct packed {
    logic      en;
    ocl_addr_t addr;
    ocl_data_t data;
  } reg_wr_t;

  // Register map
  localparam ocl_addr_t HELLO_ADDR = 32'h0000_0500;
  localparam ocl_addr_t VLED_ADDR  = 32'h0000_0504;
  localparam ocl_addr_t X_ADDR     = 32'h0000_0508;
  localparam ocl_addr_t Y_ADDR     = 32'h0000_050C;
  localparam ocl_addr_t Z_ADDR     = 32'h0000_0510;

  // Returned for any address outside the map
  localparam ocl_data_t UNIMPLEMENTED_VALUE = 32'hDEAF_BEEF;

  // Only response the block ever gives
  localparam ocl_resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: logic/hello_top.sv
// ---------------------------------------------------------------------
// Top level of the hello register block
// Bus controller in front, register bank and LED status behind it
// VLED_W is set here and passed to both datapath blocks
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module hello_top
  import hello_pkg::*;
#(
  parameter int VLED_W = 16
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  ocl_req_t          ocl_req,
  output ocl_rsp_t          ocl_rsp,
  input  logic [VLED_W-1:0] vdip,
  output logic [VLED_W-1:0] vled
);

  // ------------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------------
  // Controller to bank
  reg_wr_t           reg_wr;
  ocl_addr_t         rd_addr;
  // Bank back to controller
  ocl_data_t         rd_data;
  // Bank to LED block and back
  ocl_data_t         greeting;
  logic [VLED_W-1:0] vled_shadow;

  // ------------------------------------------------------------------
  // Bus controller
  // ------------------------------------------------------------------
  ocl_bus_ctrl u_bus_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // ------------------------------------------------------------------
  // Register bank
  // ------------------------------------------------------------------
  user_reg_bank #(
    .VLED_W (VLED_W)
  ) u_reg_bank (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .greeting        (greeting),
    .vled_shadow     (vled_shadow)
  );

  // ------------------------------------------------------------------
  // LED shadow and DIP masking
  // ------------------------------------------------------------------
  vled_status #(
    .VLED_W (VLED_W)
  ) u_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .greeting        (greeting),
    .vdip            (vdip),
    .vled            (vled),
    .vled_shadow     (vled_shadow)
  );

endmodule

`default_nettype wire

// File: logic/ocl_bus_ctrl.sv
// ---------------------------------------------------------------------
// Single-beat AXI-Lite style slave controller
// One write and one read in flight at a time; write becomes a
// one-cycle strobe into the register bank, read data is captured
// from the bank two edges after the address is accepted
// bvalid, rvalid and rdata are held until the master takes them
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ocl_bus_ctrl
  import hello_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  input  ocl_req_t  ocl_req,
  output ocl_rsp_t  ocl_rsp,
  output reg_wr_t   reg_wr,
  output ocl_addr_t rd_addr,
  input  ocl_data_t rd_data
);

  // ------------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------------
  logic      wr_active;
  ocl_addr_t wr_addr;
  logic      awready;
  logic      wready;
  logic      bvalid_q;

  // New address only while idle
  assign awready = ~wr_active;

  // Data taken in the same cycle it shows up
  // Blocked once the response is out so a stray beat is not re-accepted
  assign wready = wr_active & ~bvalid_q & ocl_req.wvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      // Active from the cycle after the address, until B handshake
      if (wr_active && bvalid_q && ocl_req.bready) begin
        wr_active <= 1'b0;
      end else if (!wr_active && ocl_req.awvalid) begin
        wr_active <= 1'b1;
      end
      // Response one cycle after the data beat
      if (bvalid_q && ocl_req.bready) begin
        bvalid_q <= 1'b0;
      end else if (wready) begin
        bvalid_q <= 1'b1;
      end
    end
  end

  // Address register, payload only
  always_ff @(posedge clk_main_a0) begin
    if (awready && ocl_req.awvalid) begin
      wr_addr <= ocl_req.awaddr;
    end
  end

  // Strobe into the bank, target updates at this edge
  assign reg_wr.en   = wready;
  assign reg_wr.addr = wr_addr;
  assign reg_wr.data = ocl_req.wdata;

  // ------------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------------
  logic      arready;
  logic      ar_accept;
  logic      rd_pending;
  logic      rd_lookup;
  ocl_addr_t rd_addr_q;
  logic      rvalid_q;
  ocl_data_t rdata_q;

  // Closed from accept until the data is taken
  assign arready   = ~rd_pending & ~rd_lookup & ~rvalid_q;
  assign ar_accept = ocl_req.arvalid & arready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pending <= 1'b0;
      rd_lookup  <= 1'b0;
      rvalid_q   <= 1'b0;
      rdata_q    <= '0;
    end else begin
      // Two-stage pipe: accept, lookup, then data valid
      rd_pending <= ar_accept;
      rd_lookup  <= rd_pending;
      if (rvalid_q && ocl_req.rready) begin
        rvalid_q <= 1'b0;
        rdata_q  <= '0;
      end else if (rd_lookup) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_data;
      end
    end
  end

  // Latched only on the accepting edge
  always_ff @(posedge clk_main_a0) begin
    if (ar_accept) begin
      rd_addr_q <= ocl_req.araddr;
    end
  end

  // Bank decodes this combinationally
  assign rd_addr = rd_addr_q;

  // ------------------------------------------------------------------
  // Slave outputs
  // ------------------------------------------------------------------
  assign ocl_rsp.awready = awready;
  assign ocl_rsp.wready  = wready;
  assign ocl_rsp.bvalid  = bvalid_q;
  assign ocl_rsp.bresp   = RESP_OKAY;
  assign ocl_rsp.arready = arready;
  assign ocl_rsp.rvalid  = rvalid_q;
  assign ocl_rsp.rdata   = rdata_q;
  assign ocl_rsp.rresp   = RESP_OKAY;

  // Write response held under back-pressure
  a_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid_q && !ocl_req.bready |=> bvalid_q);

  // Read data frozen while the master stalls
  a_rdata_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid_q && !ocl_req.rready |=> rvalid_q && $stable(rdata_q));

  // One data beat per write, answered on the next cycle
  a_wready_once: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    wready |=> bvalid_q && !wready);

endmodule

`default_nettype wire

// File: logic/user_reg_bank.sv
// ---------------------------------------------------------------------
// Register bank behind the bus controller
// Greeting, X and Y load on the write strobe; Z is their sum
// Read mux is combinational on rd_addr, the controller captures it
// Greeting reads back byte-swapped, VLED shadow zero-extended
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module user_reg_bank
  import hello_pkg::*;
#(
  parameter int VLED_W = 16
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  reg_wr_t           reg_wr,
  input  ocl_addr_t         rd_addr,
  output ocl_data_t         rd_data,
  output ocl_data_t         greeting,
  input  logic [VLED_W-1:0] vled_shadow
);

  // ------------------------------------------------------------------
  // Writable registers
  // ------------------------------------------------------------------
  ocl_data_t greeting_q;
  ocl_data_t x_q;
  ocl_data_t y_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      greeting_q <= '0;
      x_q        <= '0;
      y_q        <= '0;
    end else if (reg_wr.en) begin
      case (reg_wr.addr)
        HELLO_ADDR: greeting_q <= reg_wr.data;
        X_ADDR:     x_q        <= reg_wr.data;
        Y_ADDR:     y_q        <= reg_wr.data;
        // VLED and Z are read-only, others unmapped
        default: ;
      endcase
    end
  end

  // To the LED shadow
  assign greeting = greeting_q;

  // ------------------------------------------------------------------
  // Derived read values
  // ------------------------------------------------------------------
  ocl_data_t z_sum;
  ocl_data_t hello_swapped;
  ocl_data_t vled_ext;

  // Wraps modulo 2^DATA_W
  assign z_sum = x_q + y_q;

  // Byte order reversed, byte 0 lands on top
  always_comb begin
    for (int i = 0; i < DATA_W / 8; i++) begin
      hello_swapped[DATA_W-8*(i+1) +: 8] = greeting_q[8*i +: 8];
    end
  end

  // Upper bits read as zero
  assign vled_ext = {{(DATA_W-VLED_W){1'b0}}, vled_shadow};

  // ------------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------------
  // X and Y are write-only and fall to the default
  always_comb begin
    case (rd_addr)
      HELLO_ADDR: rd_data = hello_swapped;
      VLED_ADDR:  rd_data = vled_ext;
      Z_ADDR:     rd_data = z_sum;
      default:    rd_data = UNIMPLEMENTED_VALUE;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/vled_status.sv
// ---------------------------------------------------------------------
// Virtual LED status
// Shadows the low VLED_W bits of the greeting register,
// brings the DIP switches in through a two-flop synchronizer
// and drives the LEDs as the registered AND of both
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module vled_status
  import hello_pkg::*;
#(
  // Must not exceed DATA_W
  parameter int VLED_W = 16
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  ocl_data_t         greeting,
  input  logic [VLED_W-1:0] vdip,
  output logic [VLED_W-1:0] vled,
  output logic [VLED_W-1:0] vled_shadow
);

  logic [VLED_W-1:0] shadow_q;
  logic [VLED_W-1:0] vdip_meta;
  logic [VLED_W-1:0] vdip_sync;
  logic [VLED_W-1:0] vled_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      shadow_q  <= '0;
      vdip_meta <= '0;
      vdip_sync <= '0;
      vled_q    <= '0;
    end else begin
      // One cycle behind the greeting register
      shadow_q  <= greeting[VLED_W-1:0];
      // Switches are asynchronous to clk_main_a0
      vdip_meta <= vdip;
      vdip_sync <= vdip_meta;
      // Switch low forces its LED off
      vled_q    <= shadow_q & vdip_sync;
    end
  end

  assign vled        = vled_q;
  assign vled_shadow = shadow_q;

  // No LED lit unless its switch was on at the pin three edges back
  a_vled_masked: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (vled & ~$past(vdip, 3)) == '0);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the hello register block testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_hello -f vlog.f -o sim_hello
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_hello)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^TEST OK$'; then
  exit 0
fi
exit 1

// File: sim/tb_clock.sv
// ---------------------------------------------------------------------
// Testbench clock and reset source
// Free-running clock, reset held low for a few cycles and
// released on a rising edge so it arrives synchronous
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int CLK_PERIOD = 10,
  parameter int RST_CYCLES = 3
) (
  output logic clk_main_a0,
  output logic rst_main_n_sync
);

  // Clock, starts low
  initial begin
    clk_main_a0 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;
  end

  // Reset low from time zero, released after RST_CYCLES edges
  initial begin
    rst_main_n_sync = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/tb_hello.sv
// ---------------------------------------------------------------------
// Directed testbench for the hello register block
// Drives the slave port with single-beat writes and reads,
// checks register map, sum, LED masking and back-pressure
// Prints one line per test and a closing summary
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_hello
  import hello_pkg::*;
();

  localparam int VLED_W     = 16;
  localparam int WAIT_LIMIT = 50;
  // Response flags selectable by wait_rsp
  localparam int F_AWREADY = 0;
  localparam int F_WREADY  = 1;
  localparam int F_BVALID  = 2;
  localparam int F_ARREADY = 3;
  localparam int F_RVALID  = 4;

  logic              clk_main_a0;
  logic              rst_main_n_sync;
  ocl_req_t          ocl_req;
  ocl_rsp_t          ocl_rsp;
  logic [VLED_W-1:0] vdip;
  logic [VLED_W-1:0] vled;

  logic [31:0] lfsr_state;
  string       cur_test;
  int          checks;
  int          errors;
  int          tests_run;
  int          tests_passed;
  int          test_err_base;

  tb_clock #(.CLK_PERIOD(10), .RST_CYCLES(3)) u_clock (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync)
  );

  hello_top #(.VLED_W(VLED_W)) DUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ocl_req         (ocl_req),
    .ocl_rsp         (ocl_rsp),
    .vdip            (vdip),
    .vled            (vled)
  );

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  // Galois LFSR, one step per bit taken
  function automatic ocl_data_t random_bits(input int n);
    ocl_data_t val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[DATA_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hD000_0001) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  // Expected readback of the greeting, byte 0 on top
  function automatic ocl_data_t byte_swap(input ocl_data_t d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  function automatic logic rsp_flag(input int which);
    case (which)
      F_AWREADY: return ocl_rsp.awready;
      F_WREADY:  return ocl_rsp.wready;
      F_BVALID:  return ocl_rsp.bvalid;
      F_ARREADY: return ocl_rsp.arready;
      default:   return ocl_rsp.rvalid;
    endcase
  endfunction

  task automatic compare_data(input ocl_data_t exp, input ocl_data_t act, input string what);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s (%s): expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic compare_vled(input logic [VLED_W-1:0] exp, input logic [VLED_W-1:0] act,
                              input string what);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s (%s): expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic compare_resp(input ocl_resp_t exp, input ocl_resp_t act, input string what);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s (%s): expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR in %s: %s", cur_test, msg);
  endtask

  // Handshake edge = first edge where the flag was high
  task automatic wait_rsp(input int which, input string what, output bit ok);
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk_main_a0);
      cnt++;
    end while (!rsp_flag(which) && cnt < WAIT_LIMIT);
    ok = rsp_flag(which);
    if (!ok) report_problem($sformatf("no %s within %0d cycles", what, WAIT_LIMIT));
  endtask

  // ------------------------------------------------------------------
  // Bus transactions
  // ------------------------------------------------------------------
  // Address first, data after wdelay idle cycles
  task automatic axil_write(input ocl_addr_t addr, input ocl_data_t data, input int wdelay);
    bit ok;
    @(posedge clk_main_a0);
    ocl_req.awvalid <= 1'b1;
    ocl_req.awaddr  <= addr;
    wait_rsp(F_AWREADY, "awready", ok);
    ocl_req.awvalid <= 1'b0;
    if (!ok) return;
    // No response may show up before the data beat
    repeat (wdelay) begin
      @(posedge clk_main_a0);
      if (ocl_rsp.bvalid) report_problem("bvalid before write data was sent");
    end
    ocl_req.wvalid <= 1'b1;
    ocl_req.wdata  <= data;
    ocl_req.wstrb  <= '1;
    wait_rsp(F_WREADY, "wready", ok);
    ocl_req.wvalid <= 1'b0;
    if (!ok) return;
    ocl_req.bready <= 1'b1;
    wait_rsp(F_BVALID, "bvalid", ok);
    ocl_req.bready <= 1'b0;
    // Okay is the only response
    if (ok) compare_resp(2'b00, ocl_rsp.bresp, "bresp");
  endtask

  // hold > 0 keeps rready low that many cycles once rvalid is up
  task automatic axil_read(input ocl_addr_t addr, input int hold, output ocl_data_t data);
    bit        ok;
    ocl_data_t first;
    data = '0;
    @(posedge clk_main_a0);
    ocl_req.arvalid <= 1'b1;
    ocl_req.araddr  <= addr;
    wait_rsp(F_ARREADY, "arready", ok);
    ocl_req.arvalid <= 1'b0;
    if (!ok) return;
    if (hold > 0) begin
      wait_rsp(F_RVALID, "rvalid", ok);
      if (!ok) return;
      first = ocl_rsp.rdata;
      repeat (hold) begin
        @(posedge clk_main_a0);
        if (!ocl_rsp.rvalid) report_problem("rvalid dropped while rready was low");
        if (ocl_rsp.arready) report_problem("arready high while read data was pending");
        compare_data(first, ocl_rsp.rdata, "rdata held");
      end
    end
    ocl_req.rready <= 1'b1;
    wait_rsp(F_RVALID, "rvalid", ok);
    ocl_req.rready <= 1'b0;
    if (ok) begin
      data = ocl_rsp.rdata;
      compare_resp(2'b00, ocl_rsp.rresp, "rresp");
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == test_err_base) begin
      tests_passed++;
      $display("%-14s: pass", cur_test);
    end else begin
      $display("%-14s: fail, %0d errors", cur_test, errors - test_err_base);
    end
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------
  task automatic test_reset_values();
    ocl_data_t rd;
    start_test("reset_values");
    if (!(ocl_rsp.awready && ocl_rsp.arready) || ocl_rsp.wready || ocl_rsp.bvalid
        || ocl_rsp.rvalid) report_problem("bus flags not idle after reset");
    axil_read(HELLO_ADDR, 0, rd);
    compare_data('0, rd, "hello");
    axil_read(VLED_ADDR, 0, rd);
    compare_data('0, rd, "vled reg");
    axil_read(Z_ADDR, 0, rd);
    compare_data('0, rd, "z");
    compare_vled('0, vled, "vled out");
    finish_test();
  endtask

  task automatic test_hello_swap();
    ocl_data_t wr;
    ocl_data_t rd;
    start_test("hello_swap");
    for (int i = 0; i < 3; i++) begin
      if (i == 0) wr = 32'h1234_5678;
      else wr = random_bits(DATA_W);
      axil_write(HELLO_ADDR, wr, 0);
      axil_read(HELLO_ADDR, 0, rd);
      compare_data(byte_swap(wr), rd, "hello swapped");
      axil_read(VLED_ADDR, 0, rd);
      compare_data({16'h0000, wr[15:0]}, rd, "vled shadow");
    end
    finish_test();
  endtask

  task automatic test_sum();
    ocl_data_t x;
    ocl_data_t y;
    ocl_data_t rd;
    start_test("sum");
    for (int i = 0; i < 5; i++) begin
      // Last pair wraps past 2^32
      if (i == 4) begin
        x = 32'hFFFF_FFF0;
        y = 32'h0000_0025;
      end else begin
        x = random_bits(DATA_W);
        y = random_bits(DATA_W);
      end
      axil_write(X_ADDR, x, 0);
      axil_write(Y_ADDR, y, 0);
      axil_read(Z_ADDR, 0, rd);
      compare_data(x + y, rd, "z = x + y");
    end
    finish_test();
  endtask

  task automatic test_unmapped();
    ocl_data_t rd;
    start_test("unmapped");
    axil_read(X_ADDR, 0, rd);
    compare_data(32'hDEAF_BEEF, rd, "x write-only");
    axil_read(Y_ADDR, 0, rd);
    compare_data(32'hDEAF_BEEF, rd, "y write-only");
    axil_read(32'h0000_0000, 0, rd);
    compare_data(32'hDEAF_BEEF, rd, "addr 0x000");
    axil_read(32'h0000_0514, 0, rd);
    compare_data(32'hDEAF_BEEF, rd, "addr 0x514");
    // Known contents, then read-only registers ignore writes
    axil_write(HELLO_ADDR, 32'h1357_9BDF, 0);
    axil_write(X_ADDR, 32'h0000_1000, 0);
    axil_write(Y_ADDR, 32'h0000_0234, 0);
    axil_write(VLED_ADDR, 32'hA5A5_5A5A, 0);
    axil_read(VLED_ADDR, 0, rd);
    compare_data(32'h0000_9BDF, rd, "vled after write");
    axil_read(HELLO_ADDR, 0, rd);
    compare_data(32'hDF9B_5713, rd, "hello after vled write");
    axil_write(Z_ADDR, 32'h0BAD_F00D, 0);
    axil_read(Z_ADDR, 0, rd);
    compare_data(32'h0000_1234, rd, "z after write");
    finish_test();
  endtask

  task automatic test_vled_mask();
    ocl_data_t         greet;
    ocl_data_t         rnd;
    logic [VLED_W-1:0] exp;
    int                cnt;
    start_test("vled_mask");
    greet = random_bits(DATA_W);
    axil_write(HELLO_ADDR, greet, 0);
    for (int i = 0; i < 4; i++) begin
      rnd = random_bits(VLED_W);
      @(posedge clk_main_a0);
      vdip <= rnd[VLED_W-1:0];
      exp = greet[VLED_W-1:0] & rnd[VLED_W-1:0];
      // Shadow, sync and output flops in the way
      cnt = 0;
      do begin
        @(posedge clk_main_a0);
        cnt++;
      end while (vled !== exp && cnt < WAIT_LIMIT);
      compare_vled(exp, vled, "vled masked");
    end
    finish_test();
  endtask

  task automatic test_backpressure();
    ocl_data_t wr;
    ocl_data_t rd;
    start_test("backpressure");
    wr = random_bits(DATA_W);
    axil_write(HELLO_ADDR, wr, 0);
    axil_read(HELLO_ADDR, 6, rd);
    compare_data(byte_swap(wr), rd, "held read");
    // Data beat late, then the write still lands
    wr = random_bits(DATA_W);
    axil_write(HELLO_ADDR, wr, 4);
    axil_read(HELLO_ADDR, 0, rd);
    compare_data(byte_swap(wr), rd, "late data write");
    finish_test();
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    int cnt;
    ocl_req      = '0;
    vdip         = '0;
    lfsr_state   = 32'h1573_4256;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    tests_passed = 0;
    cur_test     = "startup";

    cnt = 0;
    do begin
      @(posedge clk_main_a0);
      cnt++;
    end while (!rst_main_n_sync && cnt < WAIT_LIMIT);
    if (!rst_main_n_sync) report_problem("reset never released");

    test_reset_values();
    test_hello_swap();
    test_sum();
    test_unmapped();
    test_vled_mask();
    test_backpressure();

    repeat (2) @(posedge clk_main_a0);
    $display("%0d tests, %0d passed, %0d checks, %0d errors",
             tests_run, tests_passed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/hello_pkg.sv
logic/ocl_bus_ctrl.sv
logic/user_reg_bank.sv
logic/vled_status.sv
logic/hello_top.sv
sim/tb_clock.sv
sim/tb_hello.sv
